/* sources.f */
src/busPkg.sv
src/isaPkg.sv
src/alu.sv
src/registerFile.sv
src/controlUnit.sv
src/datapath.sv
src/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuMonitor.sv
sim/cpuTb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cpuTb -f sources.f -o cpuSim \
    && ./obj_dir/cpuSim +verilator+error+limit+100 | tee sim.log \
    && grep -q "Test passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int MemDepth   = 64;
    localparam int AddrWidth  = $clog2(MemDepth);
    localparam int LdiCount   = 8;                       // Leading ldi/out pairs
    localparam int AluCount   = 20;                      // Random ALU/out pairs after them
    localparam int RunTimeout = 4000;                    // Cycles for the whole program

    logic                         Clock;
    logic                         Reset;
    logic                         stop;
    logic [busPkg::WordWidth-1:0] memData;
    logic [busPkg::WordWidth-1:0] memAddr;
    logic                         memRead;
    logic [busPkg::WordWidth-1:0] outData;
    logic                         outStrobe;
    logic                         run;
    logic                         done;                  // Monitor finished all checks
    logic                         failed;
    logic [busPkg::WordWidth-1:0] memory [MemDepth];
    int                           cycles;

    assign memData = memory[memAddr[AddrWidth-1:0]];     // Combinational instruction read

    cpuTop uut (
        .Clock     (Clock),
        .Reset     (Reset),
        .MemData   (memData),
        .Stop      (stop),
        .MemAddr   (memAddr),
        .MemRead   (memRead),
        .OutData   (outData),
        .OutStrobe (outStrobe),
        .Run       (run)
    );

    cpuMonitor monitor (
        .Clock     (Clock),
        .Reset     (Reset),
        .Program   (memory),
        .Stop      (stop),
        .MemRead   (memRead),
        .MemAddr   (memAddr),
        .OutData   (outData),
        .OutStrobe (outStrobe),
        .Run       (run),
        .Done      (done),
        .Failed    (failed)
    );

    // ldi/out pairs lead into ALU/out pairs and a final halt
    task automatic buildProgram();
        int            pos;
        int            ra;
        logic [3:0]    rb;
        isaPkg::Opcode op;
        for (int a = 0; a < MemDepth; a++) begin
            memory[a] = {isaPkg::opHalt, 27'(a)};        // Unused words halt and carry their address
        end
        pos = 0;
        for (int i = 0; i < LdiCount + AluCount; i++) begin
            ra = $urandom_range(15);
            rb = (i % 3 == 0) ? 4'd0 : 4'($urandom_range(15));   // Every third reads rb as zero
            case ($urandom_range(2))
                0:       op = isaPkg::opAdd;
                1:       op = isaPkg::opAnd;
                default: op = isaPkg::opShr;
            endcase
            if (i < LdiCount) begin
                op = isaPkg::opLdi;
            end
            memory[pos]     = {op, 4'(ra), rb, 19'($urandom)};   // rc and constant random
            memory[pos + 1] = {isaPkg::opOut, 4'(ra), 23'($urandom)};
            pos += 2;
        end
        memory[pos] = {isaPkg::opHalt, 27'd0};
    endtask

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    initial begin
        void'($urandom(32'hc1fc_e5cd));                  // One seed for the whole run
        Reset  = 1'b1;
        stop   = 1'b0;
        cycles = 0;
        buildProgram();
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        Reset = 1'b0;
        while (!done && cycles < RunTimeout) begin
            @(negedge Clock);
            cycles++;
            if (stop) begin
                stop = ($urandom_range(2) != 0);         // Stretch ends about one time in three
            end else begin
                stop = ($urandom_range(11) == 0);
            end
        end
        if (done && !failed) begin
            $display("Test passed");
        end else begin
            if (!done) begin
                $display("Run did not finish within %0d cycles", RunTimeout);
            end
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cpuMonitor.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuMonitor (
    input  logic                         Clock,
    input  logic                         Reset,
    input  logic [busPkg::WordWidth-1:0] Program [64],   // Same image as the memory
    input  logic                         Stop,
    input  logic                         MemRead,
    input  logic [busPkg::WordWidth-1:0] MemAddr,
    input  logic [busPkg::WordWidth-1:0] OutData,
    input  logic                         OutStrobe,
    input  logic                         Run,
    output logic                         Done,
    output logic                         Failed
);

    localparam int StrobeTimeout = 200;                  // Cycles allowed per out value
    localparam int HaltTimeout   = 50;

    logic [busPkg::WordWidth-1:0] expected [$];          // Out values in program order
    logic [busPkg::WordWidth-1:0] model [busPkg::RegCount];
    logic [busPkg::WordWidth-1:0] fetchAddr  = '0;       // Straight-line code reads words in order
    logic                         stopPrev   = 1'b0;
    logic                         strobePrev = 1'b0;
    logic                         runPrev    = 1'b1;
    int                           strobeCount = 0;
    int                           stopCycles  = 0;
    int                           ruleErrors  = 0;       // Broken strobe and Run rules
    int                           addrErrors  = 0;       // Fetches from the wrong word
    int                           lateReads   = 0;       // MemRead after Run fell
    int                           errors      = 0;
    int                           tests       = 0;

    // Instruction-level model run once over the program
    task automatic predictOutputs();
        logic [busPkg::WordWidth-1:0] word;
        logic [busPkg::WordWidth-1:0] bVal;
        logic [busPkg::WordWidth-1:0] cVal;
        logic [busPkg::WordWidth-1:0] imm;
        logic [3:0]                   ra;
        logic                         halted;
        halted = 1'b0;
        for (int r = 0; r < busPkg::RegCount; r++) begin
            model[r] = '0;
        end
        for (int pc = 0; pc < $size(Program) && !halted; pc++) begin
            word = Program[pc];
            ra   = word[isaPkg::RaLsb +: 4];
            bVal = (word[isaPkg::RbLsb +: 4] == 4'd0) ? '0 : model[word[isaPkg::RbLsb +: 4]];
            cVal = model[word[isaPkg::RcLsb +: 4]];
            imm  = {{(32 - isaPkg::ConstWidth){word[isaPkg::ConstWidth-1]}},
                    word[isaPkg::ConstWidth-1:0]};       // Sign extended
            case (isaPkg::Opcode'(word[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb]))
                isaPkg::opLdi:  model[ra] = bVal + imm;
                isaPkg::opAdd:  model[ra] = bVal + cVal;    // Wraps at 32 bits
                isaPkg::opAnd:  model[ra] = bVal & cVal;
                isaPkg::opShr:  model[ra] = bVal >> cVal[4:0];
                isaPkg::opOut:  expected.push_back(model[ra]);
                isaPkg::opHalt: halted = 1'b1;
                default: begin
                end
            endcase
        end
    endtask

    // Values read here are those of the cycle just ended
    always @(posedge Clock) begin
        if (!Reset) begin
            if ((stopPrev && (MemRead || OutStrobe)) || (strobePrev && OutStrobe)) begin
                $display("Strobe rule broken at %0t: MemRead %b OutStrobe %b",
                         $time, MemRead, OutStrobe);
                ruleErrors++;
            end
            if (!runPrev && Run) begin
                $display("Run rose again at %0t after halt", $time);
                ruleErrors++;
            end
            if (MemRead && MemAddr !== fetchAddr) begin
                $display("** Error at %0t: MemAddr expected %h, got %h",
                         $time, fetchAddr, MemAddr);
                addrErrors++;
            end
            if (MemRead) fetchAddr <= fetchAddr + 1'b1;
            if (!Run && MemRead) lateReads++;
            if (OutStrobe) strobeCount++;
            if (Stop) stopCycles++;
        end
        stopPrev   <= Stop;
        strobePrev <= OutStrobe;
        runPrev    <= Run;
    end

    initial begin
        int waited;
        bit lost;
        Done   = 1'b0;
        Failed = 1'b0;
        lost   = 1'b0;
        waited = 0;
        while (Reset !== 1'b0 && waited < 20) begin
            @(posedge Clock);
            waited++;
        end
        predictOutputs();
        for (int i = 0; i < expected.size() && !lost; i++) begin
            waited = 0;
            @(posedge Clock);
            while (!OutStrobe && waited < StrobeTimeout) begin
                @(posedge Clock);
                waited++;
            end
            tests++;
            if (!OutStrobe) begin
                $display("Timed out waiting for out value %0d", i);
                lost = 1'b1;
                errors++;
            end else if (OutData !== expected[i]) begin
                $display("** Error at %0t: OutData expected %h, got %h",
                         $time, expected[i], OutData);
                errors++;
            end else begin
                $display("Out value %0d ok: %h", i, OutData);
            end
        end
        waited = 0;
        while (Run && waited < HaltTimeout) begin
            @(posedge Clock);
            waited++;
        end
        repeat (8) @(posedge Clock);                     // Window for stray reads after halt
        @(negedge Clock);                                // Counts of the last edge are in
        tests++;
        if (Run) begin
            $display("Run stayed high %0d cycles after the last out value", HaltTimeout);
            errors++;
        end else if (strobeCount != expected.size() || lateReads != 0) begin
            $display("Halt check saw %0d out values of %0d and %0d reads after halt",
                     strobeCount, expected.size(), lateReads);
            errors++;
        end else begin
            $display("Halt check ok with %0d out values", strobeCount);
        end
        tests++;
        if (ruleErrors == 0) begin
            $display("Stop check ok over %0d stopped cycles", stopCycles);
        end else begin
            $display("Stop check found %0d strobe or Run rule violations", ruleErrors);
            errors++;
        end
        tests++;
        if (addrErrors == 0) begin
            $display("Fetch address check ok over %0d fetches", fetchAddr);
        end else begin
            $display("Fetch address check found %0d wrong addresses", addrErrors);
            errors++;
        end
        $display("%0d checks run, %0d errors", tests, errors);
        @(posedge Clock);
        Failed = (errors != 0);
        Done   = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/cpuTop_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTopChk (
    input logic Clock,
    input logic Reset,
    input logic Stop,
    input logic MemRead,
    input logic OutStrobe,
    input logic Run
);

    // Output port pulse is one cycle wide
    assert property (@(posedge Clock) disable iff (Reset) OutStrobe |=> !OutStrobe)
        else $error("OutStrobe high for two cycles");

    assert property (@(posedge Clock) disable iff (Reset) $past(Stop) |-> !MemRead && !OutStrobe)
        else $error("Strobe active in the cycle after Stop");

    // Halt is final until reset
    assert property (@(posedge Clock) disable iff (Reset) !Run |=> !Run)
        else $error("Run rose again after halt");

    assert property (@(posedge Clock) disable iff (Reset) !Run |-> !MemRead)
        else $error("MemRead while halted");

endmodule

bind cpuTop cpuTopChk checks (
    .Clock     (Clock),
    .Reset     (Reset),
    .Stop      (Stop),
    .MemRead   (MemRead),
    .OutStrobe (OutStrobe),
    .Run       (Run)
);

`default_nettype wire

/* src/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  logic                         Clock,
    input  logic                         Reset,
    input  logic [busPkg::WordWidth-1:0] MemData,      // Combinational read data
    input  logic                         Stop,
    output logic [busPkg::WordWidth-1:0] MemAddr,
    output logic                         MemRead,
    output logic [busPkg::WordWidth-1:0] OutData,
    output logic                         OutStrobe,
    output logic                         Run
);

    busPkg::ControlWord controlWord;
    isaPkg::Opcode      opcode;

    controlUnit control (
        .Clock   (Clock),
        .Reset   (Reset),
        .Stop    (Stop),
        .Opcode  (opcode),
        .Control (controlWord),
        .Run     (Run)
    );

    datapath path (
        .Clock     (Clock),
        .Reset     (Reset),
        .Control   (controlWord),
        .MemData   (MemData),
        .MemAddr   (MemAddr),
        .OutData   (OutData),
        .OutStrobe (OutStrobe),
        .Opcode    (opcode)
    );

    assign MemRead = controlWord.read;                 // Fetch only

endmodule

`default_nettype wire

/* src/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic                         Clock,
    input  logic                         Reset,
    input  busPkg::ControlWord           Control,
    input  logic [busPkg::WordWidth-1:0] MemData,
    output logic [busPkg::WordWidth-1:0] MemAddr,
    output logic [busPkg::WordWidth-1:0] OutData,
    output logic                         OutStrobe,
    output isaPkg::Opcode                Opcode
);

    logic [busPkg::WordWidth-1:0] bus;
    logic [busPkg::WordWidth-1:0] pc;
    logic [busPkg::WordWidth-1:0] mar;
    logic [busPkg::WordWidth-1:0] mdr;
    logic [busPkg::WordWidth-1:0] ir;
    logic [busPkg::WordWidth-1:0] irNext;                 // IR input value
    logic [busPkg::WordWidth-1:0] y;
    logic [busPkg::WordWidth-1:0] z;
    logic [busPkg::WordWidth-1:0] regOut;
    logic [busPkg::WordWidth-1:0] aluResult;
    logic [busPkg::WordWidth-1:0] constExt;               // Sign-extended immediate

    registerFile regs (
        .Clock       (Clock),
        .Reset       (Reset),
        .Instruction (ir),
        .Gra         (Control.gra),
        .Grb         (Control.grb),
        .Grc         (Control.grc),
        .Rin         (Control.rin),
        .Rout        (Control.rout),
        .BusIn       (bus),
        .RegOut      (regOut)
    );

    alu aluUnit (
        .Op     (Control.aluOp),
        .A      (y),
        .B      (bus),
        .Result (aluResult)
    );

    assign constExt = {{(busPkg::WordWidth - isaPkg::ConstWidth){ir[isaPkg::ConstWidth-1]}},
                       ir[isaPkg::ConstWidth-1:0]};

    // One-hot bus, regOut is already zero unless rout
    assign bus = regOut
               | ({busPkg::WordWidth{Control.zLowOut}} & z)
               | ({busPkg::WordWidth{Control.pcOut}}   & pc)
               | ({busPkg::WordWidth{Control.mdrOut}}  & mdr)
               | ({busPkg::WordWidth{Control.cOut}}    & constExt);

    assign irNext  = Control.irIn ? bus : ir;
    assign Opcode  = isaPkg::Opcode'(irNext[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb]);
    assign MemAddr = mar;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc        <= '0;                              // Execution starts at word 0
            mar       <= '0;
            ir        <= '0;
            OutData   <= '0;
            OutStrobe <= 1'b0;
        end else begin
            if (Control.pcIn) begin
                pc <= bus;
            end
            if (Control.marIn) begin
                mar <= bus;
            end
            ir        <= irNext;
            OutStrobe <= Control.outPortIn;               // One cycle after the load
            if (Control.outPortIn) begin
                OutData <= bus;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (Control.mdrIn) begin
            mdr <= Control.read ? MemData : bus;
        end
        if (Control.yin) begin
            y <= bus;
        end
        if (Control.zin) begin
            z <= Control.incPc ? pc + busPkg::WordWidth'(1) : aluResult;
        end
    end

endmodule

`default_nettype wire

/* src/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic               Clock,
    input  logic               Reset,
    input  logic               Stop,
    input  isaPkg::Opcode      Opcode,                 // Opcode field of IR input
    output busPkg::ControlWord Control,
    output logic               Run
);

    isaPkg::SeqState state;
    isaPkg::SeqState nextState;
    logic            stopSeen;                         // Stop as seen at last edge
    logic            stall;
    busPkg::AluOp    execOp;                           // ALU op of instruction in IR
    logic            execLdi;                          // Instruction in IR is ldi

    // Stall covers the Stop cycle and the one after it
    assign stall = Stop | stopSeen;
    assign Run   = (state != isaPkg::haltState);

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state    <= isaPkg::resetState;
            stopSeen <= 1'b0;
            execOp   <= busPkg::aluPass;
            execLdi  <= 1'b0;
        end else begin
            stopSeen <= Stop;
            if (!stall) begin
                state <= nextState;
            end
            if (!stall && state == isaPkg::fetch2) begin   // Latch decode as IR loads
                execLdi <= (Opcode == isaPkg::opLdi);
                case (Opcode)
                    isaPkg::opAnd: execOp <= busPkg::aluAnd;
                    isaPkg::opShr: execOp <= busPkg::aluShr;
                    default:       execOp <= busPkg::aluAdd;   // add and ldi
                endcase
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            isaPkg::resetState: nextState = isaPkg::fetch0;
            isaPkg::fetch0:     nextState = isaPkg::fetch1;
            isaPkg::fetch1:     nextState = isaPkg::fetch2;
            isaPkg::fetch2: begin
                case (Opcode)
                    isaPkg::opLdi,
                    isaPkg::opAdd,
                    isaPkg::opAnd,
                    isaPkg::opShr:  nextState = isaPkg::exec3;
                    isaPkg::opOut:  nextState = isaPkg::outExec3;
                    isaPkg::opHalt: nextState = isaPkg::haltState;
                    default:        nextState = isaPkg::fetch0;   // Undefined opcode
                endcase
            end
            isaPkg::exec3:      nextState = isaPkg::exec4;
            isaPkg::exec4:      nextState = isaPkg::exec5;
            isaPkg::exec5:      nextState = isaPkg::fetch0;
            isaPkg::outExec3:   nextState = isaPkg::fetch0;
            isaPkg::haltState:  nextState = isaPkg::haltState;   // Until reset
            default:            nextState = isaPkg::resetState;
        endcase
    end

    // Strobes for the present state, all low while stalled
    always_comb begin
        Control       = '0;
        Control.aluOp = busPkg::aluPass;
        if (!stall) begin
            case (state)
                isaPkg::fetch0: begin
                    Control.pcOut = 1'b1;              // PC onto bus
                    Control.marIn = 1'b1;
                    Control.incPc = 1'b1;
                    Control.zin   = 1'b1;              // Z = PC + 1
                end
                isaPkg::fetch1: begin
                    Control.zLowOut = 1'b1;
                    Control.pcIn    = 1'b1;            // PC = Z
                    Control.read    = 1'b1;
                    Control.mdrIn   = 1'b1;            // MDR = memory word
                end
                isaPkg::fetch2: begin
                    Control.mdrOut = 1'b1;
                    Control.irIn   = 1'b1;
                end
                isaPkg::exec3: begin
                    Control.grb  = 1'b1;               // rb to Y
                    Control.rout = 1'b1;
                    Control.yin  = 1'b1;
                end
                isaPkg::exec4: begin
                    if (execLdi) begin
                        Control.cOut = 1'b1;           // Immediate operand
                    end else begin
                        Control.grc  = 1'b1;
                        Control.rout = 1'b1;
                    end
                    Control.aluOp = execOp;
                    Control.zin   = 1'b1;
                end
                isaPkg::exec5: begin
                    Control.zLowOut = 1'b1;            // Write back to ra
                    Control.gra     = 1'b1;
                    Control.rin     = 1'b1;
                end
                isaPkg::outExec3: begin
                    Control.gra       = 1'b1;
                    Control.rout      = 1'b1;
                    Control.outPortIn = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                         Clock,
    input  logic                         Reset,
    input  logic [busPkg::WordWidth-1:0] Instruction,
    input  logic                         Gra,
    input  logic                         Grb,
    input  logic                         Grc,
    input  logic                         Rin,
    input  logic                         Rout,
    input  logic [busPkg::WordWidth-1:0] BusIn,
    output logic [busPkg::WordWidth-1:0] RegOut
);

    logic [busPkg::WordWidth-1:0]     regs [busPkg::RegCount];
    logic [busPkg::RegIndexWidth-1:0] raField;
    logic [busPkg::RegIndexWidth-1:0] rbField;
    logic [busPkg::RegIndexWidth-1:0] rcField;
    logic [busPkg::RegIndexWidth-1:0] sel;         // Index picked by the select lines
    logic                             zeroRead;    // rb field of zero reads as zero

    assign raField = Instruction[isaPkg::RaLsb +: busPkg::RegIndexWidth];
    assign rbField = Instruction[isaPkg::RbLsb +: busPkg::RegIndexWidth];
    assign rcField = Instruction[isaPkg::RcLsb +: busPkg::RegIndexWidth];

    // Selects are one-hot from the sequencer
    assign sel = ({busPkg::RegIndexWidth{Gra}} & raField)
               | ({busPkg::RegIndexWidth{Grb}} & rbField)
               | ({busPkg::RegIndexWidth{Grc}} & rcField);

    assign zeroRead = Grb && (rbField == '0);
    assign RegOut   = (Rout && !zeroRead) ? regs[sel] : '0;   // Zero when not driving

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < busPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (Rin) begin
            regs[sel] <= BusIn;
        end
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  busPkg::AluOp                 Op,
    input  logic [busPkg::WordWidth-1:0] A,            // From Y
    input  logic [busPkg::WordWidth-1:0] B,            // From bus
    output logic [busPkg::WordWidth-1:0] Result
);

    logic [busPkg::ShiftWidth-1:0] shiftAmount;

    assign shiftAmount = B[busPkg::ShiftWidth-1:0];   // Low five bits only

    always_comb begin
        case (Op)
            busPkg::aluAdd: Result = A + B;            // Carry out dropped
            busPkg::aluAnd: Result = A & B;
            busPkg::aluShr: Result = A >> shiftAmount; // Zero fill
            default:        Result = B;                // aluPass
        endcase
    end

endmodule

`default_nettype wire

/* src/isaPkg.sv */
`default_nettype none

package isaPkg;

    // Instruction field layout
    localparam int OpcodeMsb  = 31;
    localparam int OpcodeLsb  = 27;
    localparam int RaLsb      = 23;                    // ra in 26..23
    localparam int RbLsb      = 19;                    // rb in 22..19
    localparam int RcLsb      = 15;                    // rc in 18..15
    localparam int ConstWidth = 15;                    // Immediate in 14..0

    typedef enum logic [4:0] {
        opLdi  = 5'b00001,                             // ra = rb + const
        opAdd  = 5'b00011,                             // ra = rb + rc
        opAnd  = 5'b00100,                             // ra = rb & rc
        opShr  = 5'b00101,                             // ra = rb >> rc[4:0]
        opOut  = 5'b10101,                             // Output port = ra
        opHalt = 5'b11011                              // Stop sequencing
    } Opcode;

    typedef enum logic [3:0] {
        resetState = 4'd0,
        fetch0     = 4'd1,                             // PC to MAR, PC+1 to Z
        fetch1     = 4'd2,                             // Z to PC, memory to MDR
        fetch2     = 4'd3,                             // MDR to IR
        exec3      = 4'd4,                             // rb to Y
        exec4      = 4'd5,                             // ALU result to Z
        exec5      = 4'd6,                             // Z to ra
        outExec3   = 4'd7,                             // ra to output port
        haltState  = 4'd8
    } SeqState;

endpackage

`default_nettype wire

/* src/busPkg.sv */
`default_nettype none

package busPkg;

    localparam int WordWidth     = 32;                 // Bus and register width
    localparam int RegCount      = 16;                 // General registers
    localparam int RegIndexWidth = 4;                  // Index into the register file
    localparam int ShiftWidth    = 5;                  // Shift amount bits taken from B

    typedef enum logic [1:0] {
        aluAdd  = 2'd0,                                // Wrapping sum
        aluAnd  = 2'd1,                                // Bitwise and
        aluShr  = 2'd2,                                // Logical shift right
        aluPass = 2'd3                                 // B straight through
    } AluOp;

    // One strobe word per sequencer cycle
    typedef struct packed {
        logic gra;                                     // Select ra field
        logic grb;                                     // Select rb field
        logic grc;                                     // Select rc field
        logic rout;                                    // Register file drives bus
        logic zLowOut;                                 // Z drives bus
        logic pcOut;                                   // PC drives bus
        logic mdrOut;                                  // MDR drives bus
        logic cOut;                                    // Sign-extended constant drives bus
        logic rin;                                     // Register file loads from bus
        logic yin;                                     // Y loads from bus
        logic zin;                                     // Z loads ALU result
        logic pcIn;                                    // PC loads from bus
        logic marIn;                                   // MAR loads from bus
        logic mdrIn;                                   // MDR loads
        logic irIn;                                    // IR loads from bus
        logic outPortIn;                               // Output port loads from bus
        logic incPc;                                   // Z takes PC plus 1
        logic read;                                    // Memory read strobe
        AluOp aluOp;
    } ControlWord;

endpackage

`default_nettype wire
